// ==== Makefile ====
TOP = tb_conflict_serializer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1; st=$$?; cat sim.log; \
	if [ $$st -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dv/serializer_assertions.sv ====
`timescale 1ns/1ps

module serializer_assertions (
   input  logic                                                     clk,
   input  logic                                                     rstn,
   input  logic [serializer_cfg_pkg::NUM_CORES-1:0]                 s_arvalid,
   input  serializer_task_pkg::task_type_t [serializer_cfg_pkg::NUM_CORES-1:0] s_araddr,
   input  logic [serializer_cfg_pkg::NUM_CORES-1:0]                 s_rvalid,
   input  serializer_task_pkg::task_type_t                          s_rdata_ttype,
   input  serializer_task_pkg::hint_t                               s_rdata_hint,
   input  logic                                                     m_valid,
   input  logic                                                     m_ready
);

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   // one sticky flag per property
   logic fail_onehot = 1'b0;
   logic fail_pulse = 1'b0;
   logic fail_requested = 1'b0;
   logic fail_type = 1'b0;
   logic fail_ro_bit = 1'b0;
   logic fail_ready = 1'b0;
   logic failed;

   task_type_t [NUM_CORES-1:0] req_type_q;
   core_id_t                   rv_core;

   // requested types as seen at the grant edge
   always_ff @(posedge clk) begin
      req_type_q <= s_araddr;
   end

   always_comb begin
      rv_core = '0;
      for (int k = 0; k < NUM_CORES; k++) begin
         if (s_rvalid[k]) begin
            rv_core = core_id_t'(k);
         end
      end
   end

   a_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_rvalid))
      else begin
         $error("more than one core granted in a cycle");
         fail_onehot = 1'b1;
      end

   // a strobe lasts one cycle and the same core is not served twice in a row
   a_pulse: assert property (@(posedge clk) disable iff (!rstn)
      (|s_rvalid) |=> ((s_rvalid & $past(s_rvalid)) == '0))
      else begin
         $error("grant strobe held on one core for two cycles");
         fail_pulse = 1'b1;
      end

   a_requested: assert property (@(posedge clk) disable iff (!rstn)
      (|s_rvalid) |-> ((s_rvalid & ~$past(s_arvalid)) == '0))
      else begin
         $error("grant to a core that was not requesting");
         fail_requested = 1'b1;
      end

   a_type: assert property (@(posedge clk) disable iff (!rstn)
      (|s_rvalid) |-> (s_rdata_ttype == req_type_q[rv_core]))
      else begin
         $error("granted task type differs from the requested type");
         fail_type = 1'b1;
      end

   a_ro_bit: assert property (@(posedge clk) disable iff (!rstn)
      (|s_rvalid) |-> !s_rdata_hint[HINT_WIDTH-1])
      else begin
         $error("read-only bit still set on a granted hint");
         fail_ro_bit = 1'b1;
      end

   a_ready: assert property (@(posedge clk) disable iff (!rstn) m_ready |-> m_valid)
      else begin
         $error("m_ready raised without m_valid");
         fail_ready = 1'b1;
      end

   assign failed = |{fail_onehot, fail_pulse, fail_requested, fail_type, fail_ro_bit,
                     fail_ready};

endmodule

bind conflict_serializer serializer_assertions i_assertions (
   .clk           (clk),
   .rstn          (rstn),
   .s_arvalid     (s_arvalid),
   .s_araddr      (s_araddr),
   .s_rvalid      (s_rvalid),
   .s_rdata_ttype (s_rdata_ttype),
   .s_rdata_hint  (s_rdata_hint),
   .m_valid       (m_valid),
   .m_ready       (m_ready)
);

// ==== dv/tb_conflict_serializer.sv ====
`timescale 1ns/1ps

module tb_conflict_serializer;

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   localparam int RANDOM_OPS = 40;
   // each op takes at most about eight cycles, plus the directed scenarios
   localparam int TIMEOUT_CYCLES = 2 * (RANDOM_OPS * 8 + 200);

   logic                             clk = 1'b0;
   logic                             rstn;
   logic [NUM_CORES-1:0]             s_arvalid;
   task_type_t [NUM_CORES-1:0]       s_araddr;
   logic [NUM_CORES-1:0]             s_rvalid;
   task_type_t                       s_rdata_ttype;
   hint_t                            s_rdata_hint;
   cq_slot_t                         s_cq_slot;
   logic                             finished_task_valid;
   core_id_t                         finished_task_core;
   logic                             m_valid;
   task_type_t                       m_ttype;
   hint_t                            m_hint;
   cq_slot_t                         m_cq_slot;
   logic                             m_ready;
   logic                             almost_full;
   logic                             all_cores_idle;

   // model of the ready list in age order, and of the running hints
   hint_t                            list_hint[$];
   task_type_t                       list_type[$];
   cq_slot_t                         list_slot[$];
   logic [NUM_CORES-1:0]             run_valid;
   hint_t                            run_hint[NUM_CORES];
   int unsigned                      lcg_state = 93;
   int                               cycle_count = 0;

   conflict_serializer i_conflict_serializer (
      .clk                 (clk),
      .rstn                (rstn),
      .s_arvalid           (s_arvalid),
      .s_araddr            (s_araddr),
      .s_rvalid            (s_rvalid),
      .s_rdata_ttype       (s_rdata_ttype),
      .s_rdata_hint        (s_rdata_hint),
      .s_cq_slot           (s_cq_slot),
      .finished_task_valid (finished_task_valid),
      .finished_task_core  (finished_task_core),
      .m_valid             (m_valid),
      .m_ttype             (m_ttype),
      .m_hint              (m_hint),
      .m_cq_slot           (m_cq_slot),
      .m_ready             (m_ready),
      .almost_full         (almost_full),
      .all_cores_idle      (all_cores_idle)
   );

   always #5 clk = ~clk;

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic value_error(input string msg);
      stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   // oldest entry of type t with no running or older listed twin, or -1
   function automatic int expected_index(input task_type_t t);
      logic blocked;
      for (int i = 0; i < list_hint.size(); i++) begin
         blocked = 1'b0;
         for (int k = 0; k < NUM_CORES; k++) begin
            if (run_valid[k] && run_hint[k] == list_hint[i]) blocked = 1'b1;
         end
         for (int j = 0; j < i; j++) begin
            if (list_hint[j] == list_hint[i]) blocked = 1'b1;
         end
         if (!blocked && list_type[i] == t) return i;
      end
      return -1;
   endfunction

   task automatic enqueue(input task_type_t t, input hint_t h);
      cq_slot_t slot;
      slot = cq_slot_t'(lcg_next());
      @(negedge clk);
      m_valid = 1'b1;
      m_ttype = t;
      m_hint = h;
      m_cq_slot = slot;
      #1;
      while (!m_ready) begin
         if (list_hint.size() <= FULL_THRESHOLD) value_error("m_ready low with space free");
         @(negedge clk);
         #1;
      end
      if (list_hint.size() > FULL_THRESHOLD) value_error("m_ready high on a full list");
      @(posedge clk);
      // the read-only marker never reaches the list
      list_hint.push_back(h & 16'h7fff);
      list_type.push_back(t);
      list_slot.push_back(slot);
      @(negedge clk);
      m_valid = 1'b0;
   endtask

   task automatic request(input int core, input task_type_t t);
      int exp;
      exp = expected_index(t);
      @(negedge clk);
      s_arvalid[core] = 1'b1;
      s_araddr[core] = t;
      @(negedge clk);
      if (exp < 0) begin
         repeat (3) begin
            if (s_rvalid != '0) value_error("grant with no eligible entry");
            @(negedge clk);
         end
         s_arvalid[core] = 1'b0;
         @(negedge clk);
         if (s_rvalid != '0) value_error("grant with no eligible entry");
      end else begin
         if (s_rvalid != (NUM_CORES'(1) << core)) begin
            value_error($sformatf("no grant to core %0d one cycle after request", core));
         end
         if (s_rdata_hint != list_hint[exp]) begin
            value_error($sformatf("hint %h, expected %h", s_rdata_hint, list_hint[exp]));
         end
         if (s_cq_slot != list_slot[exp]) begin
            value_error($sformatf("cq slot %0d, expected %0d", s_cq_slot, list_slot[exp]));
         end
         s_arvalid[core] = 1'b0;
         @(posedge clk);
         run_valid[core] = 1'b1;
         run_hint[core] = list_hint[exp];
         list_hint.delete(exp);
         list_type.delete(exp);
         list_slot.delete(exp);
      end
   endtask

   // every core asks for type t at once and drops out one cycle after its grant
   task automatic request_together(input task_type_t t);
      logic [NUM_CORES-1:0] last;
      int exp;
      last = '0;
      @(negedge clk);
      for (int k = 0; k < NUM_CORES; k++) begin
         s_arvalid[k] = 1'b1;
         s_araddr[k] = t;
      end
      // grants go lowest core first and skip the core served last cycle
      for (int k = 0; k < NUM_CORES; k++) begin
         @(negedge clk);
         s_arvalid = s_arvalid & ~last;
         exp = expected_index(t);
         if (exp < 0) value_error("no eligible entry left for a waiting core");
         if (s_rvalid != (NUM_CORES'(1) << k)) begin
            value_error($sformatf("grant mask %b, expected core %0d", s_rvalid, k));
         end
         if (s_rdata_hint != list_hint[exp]) begin
            value_error($sformatf("hint %h, expected %h", s_rdata_hint, list_hint[exp]));
         end
         if (s_cq_slot != list_slot[exp]) begin
            value_error($sformatf("cq slot %0d, expected %0d", s_cq_slot, list_slot[exp]));
         end
         last = s_rvalid;
         @(posedge clk);
         run_valid[k] = 1'b1;
         run_hint[k] = list_hint[exp];
         list_hint.delete(exp);
         list_type.delete(exp);
         list_slot.delete(exp);
      end
      @(negedge clk);
      s_arvalid = '0;
      if (s_rvalid != '0) value_error("core granted again right after its grant");
   endtask

   task automatic finish(input int core);
      @(negedge clk);
      finished_task_valid = 1'b1;
      finished_task_core = core_id_t'(core);
      @(posedge clk);
      run_valid[core] = 1'b0;
      @(negedge clk);
      finished_task_valid = 1'b0;
   endtask

   // finish everything, then the head entry is always grantable
   task automatic drain();
      for (int k = 0; k < NUM_CORES; k++) begin
         if (run_valid[k]) finish(k);
      end
      while (list_hint.size() > 0) begin
         request(0, list_type[0]);
         finish(0);
      end
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         stop_run($sformatf("timeout after %0d cycles, the run did not complete", cycle_count));
      end
   end

   always @(negedge clk) begin
      if (i_conflict_serializer.i_assertions.failed) begin
         stop_run($sformatf("a bound assertion failed before %0t ns", $time));
      end
      if (rstn) begin
         if (almost_full !== (list_hint.size() >= ALMOST_FULL_THRESHOLD)) begin
            value_error($sformatf("almost_full %b at occupancy %0d", almost_full,
                                  list_hint.size()));
         end
         if (all_cores_idle !== (list_hint.size() == 0 && run_valid == '0)) begin
            value_error($sformatf("all_cores_idle %b does not match the model", all_cores_idle));
         end
      end
   end

   initial begin
      int core;
      int op;
      task_type_t t;
      rstn = 1'b0;
      s_arvalid = '0;
      s_araddr = '0;
      finished_task_valid = 1'b0;
      finished_task_core = '0;
      m_valid = 1'b0;
      m_ttype = '0;
      m_hint = '0;
      m_cq_slot = '0;
      run_valid = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      // random mix over a small hint set so conflicts are frequent
      for (int n = 0; n < RANDOM_OPS; n++) begin
         op = lcg_next() % 4;
         core = lcg_next() % NUM_CORES;
         t = task_type_t'(lcg_next());
         if (op < 2 && list_hint.size() < READY_LIST_SIZE) begin
            enqueue(t, hint_t'(lcg_next()) & 16'h8003);
         end else if (op == 2 && !run_valid[core]) begin
            request(core, t);
         end else if (op == 3 && run_valid[core]) begin
            finish(core);
         end
      end
      drain();

      // two tasks on one hint run one after the other
      enqueue(1, 16'h0042);
      enqueue(1, 16'h0042);
      request(0, 1);
      request(1, 1);
      finish(0);
      request(1, 1);
      finish(1);

      // read-only copy of a hint still conflicts with the plain one
      enqueue(2, 16'h8077);
      enqueue(2, 16'h0077);
      request(2, 2);
      request(3, 2);
      finish(2);
      request(3, 2);
      finish(3);

      // all cores ask at once, with an entry of another type in between
      enqueue(3, 16'h0300);
      enqueue(1, 16'h0310);
      enqueue(3, 16'h0301);
      enqueue(3, 16'h0302);
      enqueue(3, 16'h0303);
      request_together(3);
      drain();

      // fill the list, then a held task goes in once a grant frees space
      for (int i = 0; i < READY_LIST_SIZE; i++) begin
         enqueue(task_type_t'(lcg_next()), hint_t'(16'h0100 + i));
      end
      fork
         enqueue(0, 16'h0200);
         begin
            repeat (4) @(negedge clk);
            request(0, list_type[0]);
         end
      join
      drain();

      @(negedge clk);
      if (i_conflict_serializer.i_assertions.failed) begin
         stop_run("a bound assertion failed during the run");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
verilog/serializer_cfg_pkg.sv
verilog/serializer_task_pkg.sv
verilog/lowbit_select.sv
verilog/core_arbiter.sv
verilog/ready_list.sv
verilog/running_hint_table.sv
verilog/conflict_serializer.sv
dv/serializer_assertions.sv
dv/tb_conflict_serializer.sv

// ==== verilog/conflict_serializer.sv ====
`timescale 1ns/1ps

module conflict_serializer (
   input  logic                                   clk,
   input  logic                                   rstn,
   // core side
   input  logic [serializer_cfg_pkg::NUM_CORES-1:0] s_arvalid,
   input  serializer_task_pkg::task_type_t [serializer_cfg_pkg::NUM_CORES-1:0] s_araddr,
   output logic [serializer_cfg_pkg::NUM_CORES-1:0] s_rvalid,
   output serializer_task_pkg::task_type_t        s_rdata_ttype,
   output serializer_task_pkg::hint_t             s_rdata_hint,
   output serializer_task_pkg::cq_slot_t          s_cq_slot,
   input  logic                                   finished_task_valid,
   input  serializer_task_pkg::core_id_t          finished_task_core,
   // task queue side
   input  logic                                   m_valid,
   input  serializer_task_pkg::task_type_t        m_ttype,
   input  serializer_task_pkg::hint_t             m_hint,
   input  serializer_task_pkg::cq_slot_t          m_cq_slot,
   output logic                                   m_ready,
   output logic                                   almost_full,
   output logic                                   all_cores_idle
);

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   logic [READY_LIST_SIZE-1:0]       entry_valid;
   logic [READY_LIST_SIZE-1:0]       entry_conflict;
   task_type_t [READY_LIST_SIZE-1:0] entry_ttype;
   logic                             grant_valid;
   core_id_t                         grant_core;
   logic [LOG_READY_LIST_SIZE-1:0]   grant_slot;
   logic                             enq_conflict_running;
   logic                             release_valid;
   hint_t                            release_hint;
   logic                             list_empty;

   core_arbiter i_core_arbiter (
      .clk            (clk),
      .rstn           (rstn),
      .s_arvalid      (s_arvalid),
      .s_araddr       (s_araddr),
      .entry_valid    (entry_valid),
      .entry_conflict (entry_conflict),
      .entry_ttype    (entry_ttype),
      .s_rvalid       (s_rvalid),
      .grant_valid    (grant_valid),
      .grant_core     (grant_core),
      .grant_slot     (grant_slot)
   );

   ready_list i_ready_list (
      .clk                  (clk),
      .rstn                 (rstn),
      .m_valid              (m_valid),
      .m_ttype              (m_ttype),
      .m_hint               (m_hint),
      .m_cq_slot            (m_cq_slot),
      .m_ready              (m_ready),
      .enq_conflict_running (enq_conflict_running),
      .grant_valid          (grant_valid),
      .grant_slot           (grant_slot),
      .release_valid        (release_valid),
      .release_hint         (release_hint),
      .entry_valid          (entry_valid),
      .entry_conflict       (entry_conflict),
      .entry_ttype          (entry_ttype),
      .s_rdata_ttype        (s_rdata_ttype),
      .s_rdata_hint         (s_rdata_hint),
      .s_cq_slot            (s_cq_slot),
      .almost_full          (almost_full),
      .list_empty           (list_empty)
   );

   // incoming hint with the read-only bit dropped
   running_hint_table i_running_hint_table (
      .clk                  (clk),
      .rstn                 (rstn),
      .s_rvalid             (s_rvalid),
      .s_rdata_hint         (s_rdata_hint),
      .enq_hint             ({1'b0, m_hint[HINT_WIDTH-2:0]}),
      .finished_task_valid  (finished_task_valid),
      .finished_task_core   (finished_task_core),
      .list_empty           (list_empty),
      .enq_conflict_running (enq_conflict_running),
      .release_valid        (release_valid),
      .release_hint         (release_hint),
      .all_cores_idle       (all_cores_idle)
   );

endmodule

// ==== verilog/core_arbiter.sv ====
`timescale 1ns/1ps

module core_arbiter (
   input  logic                                                     clk,
   input  logic                                                     rstn,
   input  logic [serializer_cfg_pkg::NUM_CORES-1:0]                 s_arvalid,
   input  serializer_task_pkg::task_type_t [serializer_cfg_pkg::NUM_CORES-1:0] s_araddr,
   input  logic [serializer_cfg_pkg::READY_LIST_SIZE-1:0]           entry_valid,
   input  logic [serializer_cfg_pkg::READY_LIST_SIZE-1:0]           entry_conflict,
   input  serializer_task_pkg::task_type_t [serializer_cfg_pkg::READY_LIST_SIZE-1:0]
                                                                    entry_ttype,
   output logic [serializer_cfg_pkg::NUM_CORES-1:0]                 s_rvalid,
   output logic                                                     grant_valid,
   output serializer_task_pkg::core_id_t                            grant_core,
   output logic [serializer_cfg_pkg::LOG_READY_LIST_SIZE-1:0]       grant_slot
);

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   // entries that may be handed out, independent of their type
   logic [READY_LIST_SIZE-1:0] entry_free;

   // per task type, the entries a request of that type could take
   logic [N_TASK_TYPES-1:0][READY_LIST_SIZE-1:0] type_ready;

   logic [NUM_CORES-1:0]           can_take;
   core_id_t                       core_sel;
   logic                           core_found;
   logic [READY_LIST_SIZE-1:0]     entry_cand;
   logic [LOG_READY_LIST_SIZE-1:0] entry_sel;
   logic                           entry_found;

   for (genvar j = 0; j < READY_LIST_SIZE; j++) begin : g_entry
      // the slot handed out last cycle leaves the list at this edge
      assign entry_free[j] = entry_valid[j] & ~entry_conflict[j] &
                             ~(grant_valid & (int'(grant_slot) == j));
      for (genvar t = 0; t < N_TASK_TYPES; t++) begin : g_type
         assign type_ready[t][j] = entry_free[j] & (entry_ttype[j] == task_type_t'(t));
      end
   end

   for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
      // a core just served is skipped for one cycle
      assign can_take[k] = s_arvalid[k] & (|type_ready[s_araddr[k]]) &
                           ~(grant_valid & (int'(grant_core) == k));
      assign s_rvalid[k] = grant_valid & (int'(grant_core) == k);
   end

   lowbit_select #(
      .IN_WIDTH  (NUM_CORES),
      .OUT_WIDTH (LOG_NUM_CORES)
   ) i_core_select (
      .in    (can_take),
      .out   (core_sel),
      .found (core_found)
   );

   assign entry_cand = type_ready[s_araddr[core_sel]];

   // oldest eligible entry of the winning core's type
   lowbit_select #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) i_entry_select (
      .in    (entry_cand),
      .out   (entry_sel),
      .found (entry_found)
   );

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant_valid <= 1'b0;
      end else begin
         grant_valid <= core_found & entry_found;
      end
   end

   always_ff @(posedge clk) begin
      grant_core <= core_sel;
      // entries above last cycle's grant move down one place at this edge
      if (grant_valid && (entry_sel > grant_slot)) begin
         grant_slot <= entry_sel - 1'b1;
      end else begin
         grant_slot <= entry_sel;
      end
   end

endmodule

// ==== verilog/lowbit_select.sv ====
`timescale 1ns/1ps

module lowbit_select #(
   parameter int IN_WIDTH  = 8,
   parameter int OUT_WIDTH = 3
) (
   input  logic [IN_WIDTH-1:0]  in,
   output logic [OUT_WIDTH-1:0] out,
   output logic                 found
);

   // scan from the top so the lowest set bit is the last one written
   always_comb begin
      out   = '0;
      found = 1'b0;
      for (int i = IN_WIDTH - 1; i >= 0; i--) begin
         if (in[i]) begin
            out   = OUT_WIDTH'(i);
            found = 1'b1;
         end
      end
   end

endmodule

// ==== verilog/ready_list.sv ====
`timescale 1ns/1ps

module ready_list (
   input  logic                                               clk,
   input  logic                                               rstn,
   input  logic                                               m_valid,
   input  serializer_task_pkg::task_type_t                    m_ttype,
   input  serializer_task_pkg::hint_t                         m_hint,
   input  serializer_task_pkg::cq_slot_t                      m_cq_slot,
   output logic                                               m_ready,
   input  logic                                               enq_conflict_running,
   input  logic                                               grant_valid,
   input  logic [serializer_cfg_pkg::LOG_READY_LIST_SIZE-1:0] grant_slot,
   input  logic                                               release_valid,
   input  serializer_task_pkg::hint_t                         release_hint,
   output logic [serializer_cfg_pkg::READY_LIST_SIZE-1:0]     entry_valid,
   output logic [serializer_cfg_pkg::READY_LIST_SIZE-1:0]     entry_conflict,
   output serializer_task_pkg::task_type_t [serializer_cfg_pkg::READY_LIST_SIZE-1:0]
                                                              entry_ttype,
   output serializer_task_pkg::task_type_t                    s_rdata_ttype,
   output serializer_task_pkg::hint_t                         s_rdata_hint,
   output serializer_task_pkg::cq_slot_t                      s_cq_slot,
   output logic                                               almost_full,
   output logic                                               list_empty
);

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   hint_t                                  enq_hint;
   logic                                   enq;
   logic                                   enq_conflict;
   hint_t [READY_LIST_SIZE-1:0]            entry_hint;
   cq_slot_t [READY_LIST_SIZE-1:0]         entry_cq_slot;
   logic [READY_LIST_SIZE-1:0]             list_match;
   logic [READY_LIST_SIZE-1:0]             release_match;
   logic [READY_LIST_SIZE-1:0]             release_clear;
   logic [LOG_READY_LIST_SIZE-1:0]         insert_sel;
   logic                                   insert_found;
   logic [LOG_READY_LIST_SIZE-1:0]         release_sel;
   logic                                   release_found;
   logic [LOG_READY_LIST_SIZE:0]           occupancy;

   // contents of the next entry up, used when the list shifts down
   logic [READY_LIST_SIZE-1:0]             up_valid;
   logic [READY_LIST_SIZE-1:0]             up_conflict;
   task_type_t [READY_LIST_SIZE-1:0]       up_ttype;
   hint_t [READY_LIST_SIZE-1:0]            up_hint;
   cq_slot_t [READY_LIST_SIZE-1:0]         up_cq_slot;

   // read-only and read-write accesses to one hint must still serialize
   assign enq_hint = {1'b0, m_hint[HINT_WIDTH-2:0]};

   // first free entry, the list is kept packed toward entry 0
   lowbit_select #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) i_insert_select (
      .in    (~entry_valid),
      .out   (insert_sel),
      .found (insert_found)
   );

   // oldest entry waiting on the released hint
   lowbit_select #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) i_release_select (
      .in    (release_match),
      .out   (release_sel),
      .found (release_found)
   );

   assign m_ready = m_valid & insert_found & (occupancy <= FULL_THRESHOLD);
   assign enq = m_valid & m_ready;
   assign enq_conflict = (|list_match) | enq_conflict_running;

   assign up_valid    = entry_valid >> 1;
   assign up_conflict = (entry_conflict & ~release_clear) >> 1;
   assign up_ttype    = entry_ttype >> TASK_TYPE_WIDTH;
   assign up_hint     = entry_hint >> HINT_WIDTH;
   assign up_cq_slot  = entry_cq_slot >> $bits(cq_slot_t);

   for (genvar i = 0; i < READY_LIST_SIZE; i++) begin : g_entry
      logic shift_here;
      logic load_here;

      assign list_match[i]    = entry_valid[i] & (entry_hint[i] == enq_hint);
      assign release_match[i] = release_valid & entry_valid[i] & (entry_hint[i] == release_hint);
      assign release_clear[i] = release_found & (int'(release_sel) == i);

      // on a dequeue the new task lands one place below the free slot
      assign shift_here = grant_valid & (int'(grant_slot) <= i);
      assign load_here  = enq & (shift_here ? (int'(insert_sel) == i + 1)
                                            : (int'(insert_sel) == i));

      always_ff @(posedge clk) begin
         if (!rstn) begin
            entry_valid[i]    <= 1'b0;
            entry_conflict[i] <= 1'b0;
         end else if (load_here) begin
            entry_valid[i]    <= 1'b1;
            entry_conflict[i] <= enq_conflict;
         end else if (shift_here) begin
            entry_valid[i]    <= up_valid[i];
            entry_conflict[i] <= up_conflict[i];
         end else if (release_clear[i]) begin
            entry_conflict[i] <= 1'b0;
         end
      end

      always_ff @(posedge clk) begin
         if (load_here) begin
            entry_ttype[i]   <= m_ttype;
            entry_hint[i]    <= enq_hint;
            entry_cq_slot[i] <= m_cq_slot;
         end else if (shift_here) begin
            entry_ttype[i]   <= up_ttype[i];
            entry_hint[i]    <= up_hint[i];
            entry_cq_slot[i] <= up_cq_slot[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else begin
         case ({enq, grant_valid})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: occupancy <= occupancy;
         endcase
      end
   end

   assign almost_full = (occupancy >= ALMOST_FULL_THRESHOLD);
   assign list_empty  = ~|entry_valid;

   // slot picked last cycle, still in place until this edge
   assign s_rdata_ttype = entry_ttype[grant_slot];
   assign s_rdata_hint  = entry_hint[grant_slot];
   assign s_cq_slot     = entry_cq_slot[grant_slot];

endmodule

// ==== verilog/running_hint_table.sv ====
`timescale 1ns/1ps

module running_hint_table (
   input  logic                                   clk,
   input  logic                                   rstn,
   input  logic [serializer_cfg_pkg::NUM_CORES-1:0] s_rvalid,
   input  serializer_task_pkg::hint_t             s_rdata_hint,
   input  serializer_task_pkg::hint_t             enq_hint,
   input  logic                                   finished_task_valid,
   input  serializer_task_pkg::core_id_t          finished_task_core,
   input  logic                                   list_empty,
   output logic                                   enq_conflict_running,
   output logic                                   release_valid,
   output serializer_task_pkg::hint_t             release_hint,
   output logic                                   all_cores_idle
);

   import serializer_cfg_pkg::*;
   import serializer_task_pkg::*;

   // hint of the task on each core, all compared at once
   hint_t [NUM_CORES-1:0] running_hint;
   logic [NUM_CORES-1:0]  running_valid;
   logic [NUM_CORES-1:0]  finishing;
   logic [NUM_CORES-1:0]  hint_hit;

   for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
      assign finishing[k] = finished_task_valid & (int'(finished_task_core) == k);

      // a core finishing now no longer blocks the incoming task
      assign hint_hit[k] = running_valid[k] & (running_hint[k] == enq_hint) & ~finishing[k];

      always_ff @(posedge clk) begin
         if (!rstn) begin
            running_valid[k] <= 1'b0;
         end else if (s_rvalid[k]) begin
            running_valid[k] <= 1'b1;
         end else if (finishing[k]) begin
            running_valid[k] <= 1'b0;
         end
      end

      always_ff @(posedge clk) begin
         if (s_rvalid[k]) begin
            running_hint[k] <= s_rdata_hint;
         end
      end
   end

   assign enq_conflict_running = |hint_hit;

   assign release_valid = finished_task_valid & running_valid[finished_task_core];
   assign release_hint  = running_hint[finished_task_core];

   // nothing listed and nothing in flight
   assign all_cores_idle = list_empty & ~|running_valid;

endmodule

// ==== verilog/serializer_cfg_pkg.sv ====
package serializer_cfg_pkg;

   // worker cores served by one serializer
   localparam int NUM_CORES = 4;

   // width of a core index
   localparam int LOG_NUM_CORES = 2;

   // ready list depth, kept a power of two
   localparam int LOG_READY_LIST_SIZE = 3;
   localparam int READY_LIST_SIZE = 2 ** LOG_READY_LIST_SIZE;

   // occupancy at which almost_full is raised toward the task queue
   localparam int ALMOST_FULL_THRESHOLD = READY_LIST_SIZE - 4;

   // highest occupancy at which a new task is still taken in
   localparam int FULL_THRESHOLD = READY_LIST_SIZE - 1;

endpackage

// ==== verilog/serializer_task_pkg.sv ====
package serializer_task_pkg;

   // conflict key, two tasks with equal hints never run together
   localparam int HINT_WIDTH = 16;

   // top bit marks a read-only task, stripped before comparison
   typedef logic [HINT_WIDTH-1:0] hint_t;

   localparam int TASK_TYPE_WIDTH = 2;
   localparam int N_TASK_TYPES = 2 ** TASK_TYPE_WIDTH;

   typedef logic [TASK_TYPE_WIDTH-1:0] task_type_t;

   // index of a worker core
   typedef logic [serializer_cfg_pkg::LOG_NUM_CORES-1:0] core_id_t;

   // slot in the commit queue that owns the task
   typedef logic [4:0] cq_slot_t;

endpackage
